// File: cmd_parser_pkg.sv
// Shared constants and types for the command parser, imported by every RTL module
package cmd_parser_pkg;

    // Stream, memory data and address word width
    localparam int data_width = 32;

    // Byte address into the attached memory
    localparam int addr_width = 16;

    localparam int bytes_per_beat = data_width / 8;
    localparam int beat_shift = $clog2(bytes_per_beat);

    // Header word layout
    localparam int op_pos = 28;
    localparam int op_size = 4;
    localparam int len_size = 28;

    localparam logic [op_size-1:0] op_nop    = 4'd0;
    localparam logic [op_size-1:0] op_store  = 4'd5;
    localparam logic [op_size-1:0] op_memset = 4'd7;
    localparam logic [op_size-1:0] op_stream = 4'd8;

    // Byte length shifted down to whole beats
    typedef logic [len_size-beat_shift-1:0] beat_count_t;

    typedef logic [data_width-1:0] data_t;
    typedef logic [addr_width-1:0] addr_t;

    // Where the mover output goes
    typedef enum logic {
        dest_stream,
        dest_mem
    } dest_t;

    // Where the mover takes its beats from
    typedef enum logic {
        src_cmd,
        src_fill
    } src_t;

endpackage

// File: cmd_decoder.sv
// Command FSM that reads header, address and fill words and starts the mover and address generator
module cmd_decoder (
    input  logic                        aclk,
    input  logic                        resetn,
    input  logic                        s_cmd_valid,
    input  cmd_parser_pkg::data_t       s_cmd_data,
    output logic                        cmd_ready,
    output logic                        busy,
    output logic                        mover_start,
    output logic                        addr_start,
    output cmd_parser_pkg::beat_count_t beat_count,
    output cmd_parser_pkg::src_t        src,
    output cmd_parser_pkg::dest_t       dest,
    output cmd_parser_pkg::addr_t       base_addr,
    output cmd_parser_pkg::data_t       fill_word,
    input  logic                        mover_done,
    input  logic                        addr_done
);
    import cmd_parser_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_address,
        st_fill,
        st_wait
    } state_t;

    state_t state;
    logic   mover_seen;
    logic   addr_seen;
    logic   cmd_fire;

    assign cmd_fire = s_cmd_valid && cmd_ready;

    // The mover owns the input ready only while it pulls payload from the stream
    assign busy = (state == st_wait) && (src == src_cmd);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state       <= st_idle;
            cmd_ready   <= 1'b0;
            mover_start <= 1'b0;
            addr_start  <= 1'b0;
            mover_seen  <= 1'b0;
            addr_seen   <= 1'b0;
            src         <= src_cmd;
            dest        <= dest_stream;
        end
        else
        begin
            mover_start <= 1'b0;
            addr_start  <= 1'b0;
            case (state)
            st_idle:
            begin
                cmd_ready <= 1'b1;
                state     <= st_header;
            end
            st_header:
            begin
                if (cmd_fire)
                begin
                    beat_count <= beat_count_t'(s_cmd_data[len_size-1:0] >> beat_shift);
                    case (s_cmd_data[op_pos +: op_size])
                    op_stream:
                    begin
                        src         <= src_cmd;
                        dest        <= dest_stream;
                        cmd_ready   <= 1'b0;
                        mover_start <= 1'b1;
                        mover_seen  <= 1'b0;
                        // No address phase for a stream
                        addr_seen   <= 1'b1;
                        state       <= st_wait;
                    end
                    op_store:
                    begin
                        src   <= src_cmd;
                        dest  <= dest_mem;
                        state <= st_address;
                    end
                    op_memset:
                    begin
                        src   <= src_fill;
                        dest  <= dest_mem;
                        state <= st_address;
                    end
                    // NOP and unknown opcodes only consume the header
                    default:
                        state <= st_header;
                    endcase
                end
            end
            st_address:
            begin
                if (cmd_fire)
                begin
                    base_addr <= s_cmd_data[addr_width-1:0];
                    if (src == src_fill)
                        state <= st_fill;
                    else
                    begin
                        cmd_ready   <= 1'b0;
                        mover_start <= 1'b1;
                        addr_start  <= 1'b1;
                        mover_seen  <= 1'b0;
                        addr_seen   <= 1'b0;
                        state       <= st_wait;
                    end
                end
            end
            st_fill:
            begin
                if (cmd_fire)
                begin
                    fill_word   <= s_cmd_data;
                    cmd_ready   <= 1'b0;
                    mover_start <= 1'b1;
                    addr_start  <= 1'b1;
                    mover_seen  <= 1'b0;
                    addr_seen   <= 1'b0;
                    state       <= st_wait;
                end
            end
            st_wait:
            begin
                // The two done pulses may arrive in either order
                mover_seen <= mover_seen || mover_done;
                addr_seen  <= addr_seen || addr_done;
                if ((mover_seen || mover_done) && (addr_seen || addr_done))
                begin
                    cmd_ready <= 1'b1;
                    state     <= st_header;
                end
            end
            default:
                state <= st_idle;
            endcase
        end
    end

    a_done_in_wait: assert property (@(posedge aclk) disable iff (!resetn)
        mover_done |-> state == st_wait);

endmodule

// File: beat_mover.sv
// Moves counted beats from the command stream or the fill word to one registered output
module beat_mover (
    input  logic                        aclk,
    input  logic                        resetn,
    input  logic                        start,
    input  cmd_parser_pkg::beat_count_t beat_count,
    input  cmd_parser_pkg::src_t        src,
    input  cmd_parser_pkg::data_t       fill_word,
    input  logic                        in_valid,
    input  cmd_parser_pkg::data_t       in_data,
    output logic                        in_ready,
    output logic                        out_valid,
    output cmd_parser_pkg::data_t       out_data,
    output logic                        out_last,
    input  logic                        out_ready,
    output logic                        done
);
    import cmd_parser_pkg::*;

    beat_count_t cnt;
    src_t        src_q;
    data_t       fill_q;
    logic        run;
    logic        skid_valid;
    data_t       skid_data;
    logic        skid_last;
    beat_count_t len_q;
    beat_count_t taken;

    beat_count_t cur_cnt;
    src_t        cur_src;
    data_t       cur_data;
    logic        cur_last;
    logic        take_ready;
    logic        accept;
    logic        out_free;

    // On the start cycle the command fields come straight from the decoder
    assign cur_cnt  = start ? beat_count : cnt;
    assign cur_src  = start ? src : src_q;
    assign cur_data = (cur_src == src_fill) ? (start ? fill_word : fill_q) : in_data;
    assign cur_last = (cur_cnt == beat_count_t'(1));

    // A full skid stops the intake
    assign take_ready = (start || run) && (cur_cnt != '0) && !skid_valid;
    assign in_ready   = take_ready && (cur_src == src_cmd);
    assign accept     = take_ready && ((cur_src == src_fill) || in_valid);
    assign out_free   = out_ready || !out_valid;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            cnt        <= '0;
            src_q      <= src_cmd;
            run        <= 1'b0;
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            done       <= 1'b0;
            taken      <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                run   <= 1'b1;
                src_q <= src;
            end
            if (accept)
                cnt <= cur_cnt - 1'b1;
            else if (start)
                cnt <= beat_count;

            // Input transfers counted on their own for the length check
            if (in_valid && in_ready)
                taken <= start ? beat_count_t'(1) : taken + 1'b1;
            else if (start)
                taken <= '0;

            if (out_free)
            begin
                if (skid_valid)
                begin
                    out_valid  <= 1'b1;
                    skid_valid <= 1'b0;
                end
                else
                    out_valid <= accept;
            end
            else if (accept)
                skid_valid <= 1'b1;

            // All beats taken and the last one leaving the output stage
            if (run && !start && (cnt == '0) && !skid_valid && out_free)
            begin
                run  <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (start)
        begin
            fill_q <= fill_word;
            len_q  <= beat_count;
        end
        if (out_free)
        begin
            if (skid_valid)
            begin
                out_data <= skid_data;
                out_last <= skid_last;
            end
            else if (accept)
            begin
                out_data <= cur_data;
                out_last <= cur_last;
            end
        end
        else if (accept)
        begin
            skid_data <= cur_data;
            skid_last <= cur_last;
        end
    end

    a_out_stable: assert property (@(posedge aclk) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

    // Input transfers after the start cycle stay below the programmed length
    a_no_extra_beat: assert property (@(posedge aclk) disable iff (!resetn)
        in_valid && in_ready && !start |-> taken < len_q);

endmodule

// File: write_addr_gen.sv
// Issues one memory write address per beat, stepping up from the base address
module write_addr_gen (
    input  logic                        aclk,
    input  logic                        resetn,
    input  logic                        start,
    input  cmd_parser_pkg::addr_t       base_addr,
    input  cmd_parser_pkg::beat_count_t beat_count,
    output cmd_parser_pkg::addr_t       awaddr,
    output logic                        awvalid,
    input  logic                        awready,
    output logic                        done
);
    import cmd_parser_pkg::*;

    beat_count_t cnt;
    logic        run;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            cnt     <= '0;
            run     <= 1'b0;
            awvalid <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                cnt     <= beat_count;
                run     <= 1'b1;
                awvalid <= (beat_count != '0);
            end
            else if (run)
            begin
                if (awvalid && awready)
                begin
                    cnt <= cnt - 1'b1;
                    if (cnt == beat_count_t'(1))
                    begin
                        awvalid <= 1'b0;
                        run     <= 1'b0;
                        done    <= 1'b1;
                    end
                end
                // Zero length leaves nothing to issue
                else if (!awvalid)
                begin
                    run  <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (start)
            awaddr <= base_addr;
        else if (awvalid && awready)
            awaddr <= awaddr + addr_t'(bytes_per_beat);
    end

    a_addr_stable: assert property (@(posedge aclk) disable iff (!resetn)
        awvalid && !awready |=> awvalid && $stable(awaddr));

endmodule

// File: cmd_parser_top.sv
// Command parser top that decodes the command stream into stream output or memory writes
module cmd_parser_top (
    input  logic                  aclk,
    input  logic                  resetn,
    input  logic                  s_cmd_valid,
    output logic                  s_cmd_ready,
    input  cmd_parser_pkg::data_t s_cmd_data,
    input  logic                  s_cmd_last,
    output logic                  m_out_valid,
    input  logic                  m_out_ready,
    output cmd_parser_pkg::data_t m_out_data,
    output logic                  m_out_last,
    output cmd_parser_pkg::addr_t mem_awaddr,
    output logic                  mem_awvalid,
    input  logic                  mem_awready,
    output cmd_parser_pkg::data_t mem_wdata,
    output logic                  mem_wvalid,
    input  logic                  mem_wready
);
    import cmd_parser_pkg::*;

    logic        dec_ready;
    logic        busy;
    logic        mover_start;
    logic        addr_start;
    beat_count_t beat_count;
    src_t        src;
    dest_t       dest;
    addr_t       base_addr;
    data_t       fill_word;
    logic        mover_done;
    logic        addr_done;

    logic        mv_in_ready;
    logic        mv_valid;
    logic        mv_ready;
    data_t       mv_data;
    logic        mv_last;

    // Command boundaries come from the header lengths, so s_cmd_last has no role here
    assign s_cmd_ready = busy ? mv_in_ready : dec_ready;

    assign m_out_valid = mv_valid && (dest == dest_stream);
    assign m_out_data  = mv_data;
    assign m_out_last  = mv_last;
    assign mem_wvalid  = mv_valid && (dest == dest_mem);
    assign mem_wdata   = mv_data;
    assign mv_ready    = (dest == dest_stream) ? m_out_ready : mem_wready;

    cmd_decoder dec0 (
        .aclk        (aclk),
        .resetn      (resetn),
        .s_cmd_valid (s_cmd_valid),
        .s_cmd_data  (s_cmd_data),
        .cmd_ready   (dec_ready),
        .busy        (busy),
        .mover_start (mover_start),
        .addr_start  (addr_start),
        .beat_count  (beat_count),
        .src         (src),
        .dest        (dest),
        .base_addr   (base_addr),
        .fill_word   (fill_word),
        .mover_done  (mover_done),
        .addr_done   (addr_done)
    );

    beat_mover mover0 (
        .aclk       (aclk),
        .resetn     (resetn),
        .start      (mover_start),
        .beat_count (beat_count),
        .src        (src),
        .fill_word  (fill_word),
        .in_valid   (s_cmd_valid),
        .in_data    (s_cmd_data),
        .in_ready   (mv_in_ready),
        .out_valid  (mv_valid),
        .out_data   (mv_data),
        .out_last   (mv_last),
        .out_ready  (mv_ready),
        .done       (mover_done)
    );

    write_addr_gen awgen0 (
        .aclk       (aclk),
        .resetn     (resetn),
        .start      (addr_start),
        .base_addr  (base_addr),
        .beat_count (beat_count),
        .awaddr     (mem_awaddr),
        .awvalid    (mem_awvalid),
        .awready    (mem_awready),
        .done       (addr_done)
    );

endmodule

// File: tb_checker.sv
// Testbench checker comparing stream beats and memory writes with the expected items from tb_top
module tb_checker (
    input  logic                  aclk,
    input  logic                  resetn,
    input  logic                  m_out_valid,
    input  logic                  m_out_ready,
    input  cmd_parser_pkg::data_t m_out_data,
    input  logic                  m_out_last,
    input  cmd_parser_pkg::addr_t mem_awaddr,
    input  logic                  mem_awvalid,
    input  logic                  mem_awready,
    input  cmd_parser_pkg::data_t mem_wdata,
    input  logic                  mem_wvalid,
    input  logic                  mem_wready
);
    import cmd_parser_pkg::*;

    // Stream items are {last, data} and write items are {addr, data}
    logic [32:0] exp_stream_q[$];
    logic [47:0] exp_write_q[$];
    addr_t       got_addr_q[$];
    data_t       got_data_q[$];
    int          mismatch_count = 0;
    int          missing_count = 0;

    task automatic expect_stream(input data_t d, input logic last);
        exp_stream_q.push_back({last, d});
    endtask

    task automatic expect_write(input addr_t a, input data_t d);
        exp_write_q.push_back({a, d});
    endtask

    function automatic int items_left();
        return exp_stream_q.size() + exp_write_q.size() + got_addr_q.size()
            + got_data_q.size();
    endfunction

    task automatic check_stream(input data_t d, input logic last);
        logic [32:0] e;
        if (exp_stream_q.size() == 0)
        begin
            $display("Unexpected stream beat %h at time %0t", d, $time);
            mismatch_count++;
        end
        else
        begin
            e = exp_stream_q.pop_front();
            if (e[31:0] !== d || e[32] !== last)
            begin
                $display("CHECK FAILED at %0t: stream beat %h last %b, expected %h last %b",
                    $time, d, last, e[31:0], e[32]);
                mismatch_count++;
            end
        end
    endtask

    task automatic check_write(input addr_t a, input data_t d);
        logic [47:0] e;
        if (exp_write_q.size() == 0)
        begin
            $display("Unexpected memory write of %h at %h at time %0t", d, a, $time);
            mismatch_count++;
        end
        else
        begin
            e = exp_write_q.pop_front();
            if (e[47:32] !== a || e[31:0] !== d)
            begin
                $display("CHECK FAILED at %0t: write %h at %h, expected %h at %h",
                    $time, d, a, e[31:0], e[47:32]);
                mismatch_count++;
            end
        end
    endtask

    // Handshakes sampled mid-cycle transfer at the next rising edge
    always @(negedge aclk)
    begin
        if (resetn)
        begin
            if (m_out_valid && m_out_ready)
                check_stream(m_out_data, m_out_last);
            if (mem_awvalid && mem_awready)
                got_addr_q.push_back(mem_awaddr);
            if (mem_wvalid && mem_wready)
                got_data_q.push_back(mem_wdata);
            // Address and data channels run independently and are paired in order
            while (got_addr_q.size() > 0 && got_data_q.size() > 0)
            begin
                check_write(got_addr_q.pop_front(), got_data_q.pop_front());
            end
        end
    end

    task automatic final_report(input int other_errors, output int total);
        logic [32:0] s;
        logic [47:0] w;
        foreach (exp_stream_q[i])
        begin
            s = exp_stream_q[i];
            $display("Expected stream beat %h last %b never arrived", s[31:0], s[32]);
            missing_count++;
        end
        foreach (exp_write_q[i])
        begin
            w = exp_write_q[i];
            $display("Expected memory write of %h at %h never arrived", w[31:0], w[47:32]);
            missing_count++;
        end
        foreach (got_addr_q[i])
        begin
            $display("Write address %h never got a data beat", got_addr_q[i]);
            missing_count++;
        end
        foreach (got_data_q[i])
        begin
            $display("Write data %h never got an address", got_data_q[i]);
            missing_count++;
        end
        $display("Errors: %0d mismatches, %0d missing or unpaired, %0d other",
            mismatch_count, missing_count, other_errors);
        total = mismatch_count + missing_count + other_errors;
    endtask

endmodule

// File: tb_top.sv
// Testbench top for the command parser that reads cmd_vectors.txt, drives the DUT and ends the run
module tb_top;
    import cmd_parser_pkg::*;

    localparam int max_lines = 256;
    localparam logic [3:0] kind_input  = 4'h1;
    localparam logic [3:0] kind_stream = 4'h2;
    localparam logic [3:0] kind_write  = 4'h3;
    localparam logic [3:0] kind_end    = 4'hf;

    logic  aclk;
    logic  resetn;
    logic  s_cmd_valid;
    logic  s_cmd_ready;
    data_t s_cmd_data;
    logic  s_cmd_last;
    logic  m_out_valid;
    logic  m_out_ready;
    data_t m_out_data;
    logic  m_out_last;
    addr_t mem_awaddr;
    logic  mem_awvalid;
    logic  mem_awready;
    data_t mem_wdata;
    logic  mem_wvalid;
    logic  mem_wready;

    // Each record holds kind in [51:48], aux in [47:32] and data in [31:0]
    logic [51:0] vec_mem [0:max_lines-1];
    data_t       in_q[$];
    int          line_count;
    int          cycle_count;
    int          cycle_limit;
    logic        loaded;
    logic [31:0] lfsr;
    int          other_errors;
    int          total_errors;

    cmd_parser_top dut0 (
        .aclk        (aclk),
        .resetn      (resetn),
        .s_cmd_valid (s_cmd_valid),
        .s_cmd_ready (s_cmd_ready),
        .s_cmd_data  (s_cmd_data),
        .s_cmd_last  (s_cmd_last),
        .m_out_valid (m_out_valid),
        .m_out_ready (m_out_ready),
        .m_out_data  (m_out_data),
        .m_out_last  (m_out_last),
        .mem_awaddr  (mem_awaddr),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_wdata   (mem_wdata),
        .mem_wvalid  (mem_wvalid),
        .mem_wready  (mem_wready)
    );

    tb_checker chk0 (
        .aclk        (aclk),
        .resetn      (resetn),
        .m_out_valid (m_out_valid),
        .m_out_ready (m_out_ready),
        .m_out_data  (m_out_data),
        .m_out_last  (m_out_last),
        .mem_awaddr  (mem_awaddr),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_wdata   (mem_wdata),
        .mem_wvalid  (mem_wvalid),
        .mem_wready  (mem_wready)
    );

    // Fibonacci LFSR with taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    task automatic load_vectors();
        int         i;
        logic [3:0] kind;
        logic       found_end;
        found_end = 1'b0;
        line_count = 0;
        $readmemh("cmd_vectors.txt", vec_mem);
        for (i = 0; i < max_lines && !found_end; i++)
        begin
            kind = vec_mem[i][51:48];
            case (kind)
            kind_input:
                in_q.push_back(vec_mem[i][31:0]);
            kind_stream:
                chk0.expect_stream(vec_mem[i][31:0], vec_mem[i][32]);
            kind_write:
                chk0.expect_write(vec_mem[i][47:32], vec_mem[i][31:0]);
            kind_end:
                found_end = 1'b1;
            default:
            begin
                $display("Vector item %0d has an unknown kind %h", i, kind);
                other_errors++;
            end
            endcase
            if (!found_end)
                line_count++;
        end
        if (!found_end)
        begin
            $display("Vector file is missing or has no end marker");
            other_errors++;
        end
        cycle_limit = 16 * line_count + 200;
        loaded = 1'b1;
    endtask

    // Holds one command word on the input until the DUT accepts it
    task automatic send_word(input data_t d);
        s_cmd_valid = 1'b1;
        s_cmd_data = d;
        @(negedge aclk);
        while (!s_cmd_ready)
        begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #10;
    endtask

    initial
    begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // Random back-pressure on every ready input
    initial
    begin
        forever
        begin
            @(posedge aclk);
            #10;
            take_random_bit(m_out_ready);
            take_random_bit(mem_awready);
            take_random_bit(mem_wready);
        end
    end

    always @(posedge aclk)
    begin
        if (loaded)
        begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= cycle_limit)
            begin
                $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                chk0.final_report(other_errors + 1, total_errors);
                $display("Test failed");
                $finish;
            end
        end
    end

    initial
    begin
        resetn = 1'b0;
        s_cmd_valid = 1'b0;
        s_cmd_data = '0;
        s_cmd_last = 1'b0;
        m_out_ready = 1'b0;
        mem_awready = 1'b0;
        mem_wready = 1'b0;
        lfsr = 32'h00f7_84ba;
        loaded = 1'b0;
        cycle_count = 0;
        other_errors = 0;
        load_vectors();
        repeat (8) @(posedge aclk);
        #10;
        resetn = 1'b1;
        while (in_q.size() > 0)
        begin
            send_word(in_q.pop_front());
        end
        s_cmd_valid = 1'b0;
        // Done once every expected item is seen and the decoder takes headers again
        @(negedge aclk);
        while (!(chk0.items_left() == 0 && s_cmd_ready && !m_out_valid
                 && !mem_awvalid && !mem_wvalid))
        begin
            @(negedge aclk);
        end
        chk0.final_report(other_errors, total_errors);
        if (total_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: cmd_vectors.txt
// kind_aux_data: kind 1 input word, 2 expected stream beat (aux = last), 3 expected write (aux = addr)
// kind f ends the list
// STREAM of 5 words
1_0000_80000014
1_0000_11110001
1_0000_11110002
1_0000_11110003
1_0000_11110004
1_0000_11110005
2_0000_11110001
2_0000_11110002
2_0000_11110003
2_0000_11110004
2_0001_11110005
// NOP, then an unknown opcode
1_0000_00000008
1_0000_30000010
// STORE of 4 words at 0x0100
1_0000_50000010
1_0000_00000100
1_0000_22220001
1_0000_22220002
1_0000_22220003
1_0000_22220004
3_0100_22220001
3_0104_22220002
3_0108_22220003
3_010c_22220004
// MEMSET of 6 words at 0x0200
1_0000_70000018
1_0000_00000200
1_0000_a5a55a5a
3_0200_a5a55a5a
3_0204_a5a55a5a
3_0208_a5a55a5a
3_020c_a5a55a5a
3_0210_a5a55a5a
3_0214_a5a55a5a
// Zero length STREAM, then a STREAM of 1 word
1_0000_80000000
1_0000_80000004
1_0000_33330001
2_0001_33330001
// STORE of 1 word at 0x0300 right before a STREAM of 1 word
1_0000_50000004
1_0000_00000300
1_0000_44440001
3_0300_44440001
1_0000_80000004
1_0000_55550001
2_0001_55550001
f_0000_00000000

// File: compile.f
cmd_parser_pkg.sv
cmd_decoder.sv
beat_mover.sv
write_addr_gen.sv
cmd_parser_top.sv
tb_checker.sv
tb_top.sv

// File: Makefile
# Verilator build and run of the command parser testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^Test passed$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
